//--- Bender.yml
package:
  name: replay_queue

export_include_dirs:
  - src

sources:
  - src/ReplayPkg.sv
  - src/ReplayRecorder.sv
  - src/ReplayStorage.sv
  - src/FlushRangeTracker.sv
  - src/ReplayReleaser.sv
  - src/ReplayQueue.sv
  - target: test
    files:
      - verification/TbClockGen.sv
      - verification/ReplayQueue_asserts.sv
      - verification/ReplayQueueTb.sv

//--- src/FlushRangeTracker.sv
// Flush range tracking for the replay queue.
// Marks head ops that fall in the latched or the incoming recovery range.

`timescale 1ns/100ps

module FlushRangeTracker (
    input logic clk,
    input logic rst,
    input logic toRecovery,
    input logic flushAll,
    input ReplayPkg::ActiveListPtr flushHead,
    input ReplayPkg::ActiveListPtr flushTail,
    input ReplayPkg::RqCount occupancy,
    input logic replayNow,
    input ReplayPkg::ActiveListPtr intHeadTag,
    input ReplayPkg::ActiveListPtr memHeadTag,
    output logic flushIntHead,
    output logic flushMemHead,
    output logic flushedOpExist
);

    ReplayPkg::RqCount pendingCount;
    ReplayPkg::ActiveListPtr rangeHead;
    ReplayPkg::ActiveListPtr rangeTail;
    logic rangeAll;
    logic rangeActive;

    // Circular span from head inclusive to tail exclusive
    function automatic logic inRange(
        input logic enable,
        input ReplayPkg::ActiveListPtr head,
        input ReplayPkg::ActiveListPtr tail,
        input logic all,
        input ReplayPkg::ActiveListPtr tag
    );
        logic inSpan;
        if (head <= tail) begin
            inSpan = (tag >= head) && (tag < tail);
        end else begin
            inSpan = (tag >= head) || (tag < tail);
        end
        return enable && (all || inSpan);
    endfunction

    assign rangeActive = (pendingCount != '0);
    assign flushedOpExist = rangeActive;

    // The range takes a cycle to latch, so the incoming one is checked as well
    assign flushIntHead = inRange(rangeActive, rangeHead, rangeTail, rangeAll, intHeadTag) ||
                          inRange(toRecovery, flushHead, flushTail, flushAll, intHeadTag);
    assign flushMemHead = inRange(rangeActive, rangeHead, rangeTail, rangeAll, memHeadTag) ||
                          inRange(toRecovery, flushHead, flushTail, flushAll, memHeadTag);

    always_ff @(posedge clk) begin
        if (toRecovery) begin
            rangeHead <= flushHead;
            rangeTail <= flushTail;
            rangeAll <= flushAll;
        end
    end

    // Every entry present at recovery may hold a flushed op until it replays
    always_ff @(posedge clk) begin
        if (rst) begin
            pendingCount <= '0;
        end else if (toRecovery) begin
            pendingCount <= occupancy;
        end else if (rangeActive && replayNow) begin
            pendingCount <= pendingCount - ReplayPkg::RqCount'(1);
        end
    end

endmodule

//--- src/ReplayPkg.sv
// Vector types of the replay queue, shared by the RTL and the testbench.
// Refer to them as ReplayPkg::name.

`include "replayQueue_macros.svh"

package ReplayPkg;

    // Queue pointer and occupancy; occupancy needs one bit more to hold a full queue
    typedef logic [`RQ_INDEX_WIDTH-1:0] RqIndex;
    typedef logic [`RQ_INDEX_WIDTH:0] RqCount;

    // Cycles between two records, or between two releases
    typedef logic [`RQ_INTERVAL_WIDTH-1:0] RqInterval;

    // Age tag of an op in the active list
    typedef logic [`RQ_ACTIVE_LIST_WIDTH-1:0] ActiveListPtr;

    typedef logic [$clog2(`RQ_MSHR_NUM)-1:0] MshrId;

    typedef logic [`RQ_PAYLOAD_WIDTH-1:0] OpPayload;

    // One record word: both issue lanes plus the spacing before it
    typedef struct packed {
        logic intValid;
        ActiveListPtr intTag;
        OpPayload intPayload;
        logic memValid;
        ActiveListPtr memTag;
        logic memIsLoad;
        logic memHasMshr;
        MshrId memMshrId;
        OpPayload memPayload;
        RqInterval interval;
    } RqEntry;

endpackage

//--- src/ReplayQueue.sv
// Top level of the scheduler replay queue.
// Records issued int and mem ops, replays them with the same spacing,
// drops flushed ops and stalls the upper stages.

`timescale 1ns/100ps

`include "replayQueue_macros.svh"

module ReplayQueue (
    input logic clk,
    input logic rst,
    input logic intRecordValid,
    input ReplayPkg::ActiveListPtr intRecordTag,
    input ReplayPkg::OpPayload intRecordPayload,
    input logic memRecordValid,
    input ReplayPkg::ActiveListPtr memRecordTag,
    input logic memRecordIsLoad,
    input logic memRecordHasMshr,
    input ReplayPkg::MshrId memRecordMshrId,
    input ReplayPkg::OpPayload memRecordPayload,
    input logic [`RQ_MSHR_NUM-1:0] mshrValid,
    input logic [`RQ_MSHR_NUM-1:0] mshrReady,
    input logic toRecovery,
    input ReplayPkg::ActiveListPtr flushHead,
    input ReplayPkg::ActiveListPtr flushTail,
    input logic flushAll,
    output logic intReplayValid,
    output ReplayPkg::ActiveListPtr intReplayTag,
    output ReplayPkg::OpPayload intReplayPayload,
    output logic memReplayValid,
    output ReplayPkg::ActiveListPtr memReplayTag,
    output logic memReplayIsLoad,
    output ReplayPkg::OpPayload memReplayPayload,
    output logic replay,
    output logic stall,
    output logic flushedOpExist
);

    ReplayPkg::RqEntry recordEntry;
    ReplayPkg::RqEntry headEntry;
    ReplayPkg::RqCount occupancy;
    logic push;
    logic pop;
    logic empty;
    logic full;
    logic almostFull;
    logic anyValidStored;
    logic flushIntHead;
    logic flushMemHead;

    ReplayRecorder recorder_i (
        .clk(clk),
        .rst(rst),
        .intRecordValid(intRecordValid),
        .intRecordTag(intRecordTag),
        .intRecordPayload(intRecordPayload),
        .memRecordValid(memRecordValid),
        .memRecordTag(memRecordTag),
        .memRecordIsLoad(memRecordIsLoad),
        .memRecordHasMshr(memRecordHasMshr),
        .memRecordMshrId(memRecordMshrId),
        .memRecordPayload(memRecordPayload),
        .full(full),
        .anyValidStored(anyValidStored),
        .recordEntry(recordEntry),
        .push(push)
    );

    ReplayStorage storage_i (
        .clk(clk),
        .rst(rst),
        .push(push),
        .pop(pop),
        .recordEntry(recordEntry),
        .headEntry(headEntry),
        .empty(empty),
        .full(full),
        .almostFull(almostFull),
        .anyValidStored(anyValidStored),
        .occupancy(occupancy)
    );

    FlushRangeTracker flushTracker_i (
        .clk(clk),
        .rst(rst),
        .toRecovery(toRecovery),
        .flushAll(flushAll),
        .flushHead(flushHead),
        .flushTail(flushTail),
        .occupancy(occupancy),
        .replayNow(replay),
        .intHeadTag(headEntry.intTag),
        .memHeadTag(headEntry.memTag),
        .flushIntHead(flushIntHead),
        .flushMemHead(flushMemHead),
        .flushedOpExist(flushedOpExist)
    );

    // The registered replay bit is the replay output itself
    ReplayReleaser releaser_i (
        .clk(clk),
        .rst(rst),
        .headEntry(headEntry),
        .empty(empty),
        .flushIntHead(flushIntHead),
        .flushMemHead(flushMemHead),
        .almostFull(almostFull),
        .mshrValid(mshrValid),
        .mshrReady(mshrReady),
        .pop(pop),
        .replayNow(replay),
        .stall(stall),
        .intReplayValid(intReplayValid),
        .intReplayTag(intReplayTag),
        .intReplayPayload(intReplayPayload),
        .memReplayValid(memReplayValid),
        .memReplayTag(memReplayTag),
        .memReplayIsLoad(memReplayIsLoad),
        .memReplayPayload(memReplayPayload)
    );

endmodule

//--- src/ReplayRecorder.sv
// Input side of the replay queue.
// Packs the issued ops of both lanes with the record interval and decides the push.

`timescale 1ns/100ps

`include "replayQueue_macros.svh"

module ReplayRecorder (
    input logic clk,
    input logic rst,
    input logic intRecordValid,
    input ReplayPkg::ActiveListPtr intRecordTag,
    input ReplayPkg::OpPayload intRecordPayload,
    input logic memRecordValid,
    input ReplayPkg::ActiveListPtr memRecordTag,
    input logic memRecordIsLoad,
    input logic memRecordHasMshr,
    input ReplayPkg::MshrId memRecordMshrId,
    input ReplayPkg::OpPayload memRecordPayload,
    input logic full,
    input logic anyValidStored,
    output ReplayPkg::RqEntry recordEntry,
    output logic push
);

    ReplayPkg::RqInterval recordInterval;
    logic recordValid;

    assign recordValid = intRecordValid | memRecordValid;

    // Once a valid op is stored every cycle is pushed, bubbles included,
    // so the spacing between stored ops survives
    assign push = !rst && !full && (recordValid || anyValidStored);

    always_comb begin
        recordEntry.intValid = intRecordValid;
        recordEntry.intTag = intRecordTag;
        recordEntry.intPayload = intRecordPayload;
        recordEntry.memValid = memRecordValid;
        recordEntry.memTag = memRecordTag;
        recordEntry.memIsLoad = memRecordIsLoad;
        recordEntry.memHasMshr = memRecordHasMshr;
        recordEntry.memMshrId = memRecordMshrId;
        recordEntry.memPayload = memRecordPayload;
        recordEntry.interval = recordInterval;
    end

    // Cycles since the last push, saturating
    always_ff @(posedge clk) begin
        if (rst) begin
            recordInterval <= '0;
        end else if (push) begin
            recordInterval <= '0;
        end else if (recordInterval < ReplayPkg::RqInterval'(`RQ_MAX_INTERVAL)) begin
            recordInterval <= recordInterval + ReplayPkg::RqInterval'(1);
        end
    end

endmodule

//--- src/ReplayReleaser.sv
// Output side of the replay queue.
// Paces pops by the stored interval, holds loads waiting on their MSHR,
// and registers the replayed ops for one cycle.

`timescale 1ns/100ps

`include "replayQueue_macros.svh"

module ReplayReleaser (
    input logic clk,
    input logic rst,
    input ReplayPkg::RqEntry headEntry,
    input logic empty,
    input logic flushIntHead,
    input logic flushMemHead,
    input logic almostFull,
    input logic [`RQ_MSHR_NUM-1:0] mshrValid,
    input logic [`RQ_MSHR_NUM-1:0] mshrReady,
    output logic pop,
    output logic replayNow,
    output logic stall,
    output logic intReplayValid,
    output ReplayPkg::ActiveListPtr intReplayTag,
    output ReplayPkg::OpPayload intReplayPayload,
    output logic memReplayValid,
    output ReplayPkg::ActiveListPtr memReplayTag,
    output logic memReplayIsLoad,
    output ReplayPkg::OpPayload memReplayPayload
);

    ReplayPkg::RqInterval releaseInterval;
    logic headValid;
    logic mshrWait;

    assign headValid = headEntry.intValid || headEntry.memValid;

    // Live load whose miss data has not arrived yet.
    // A flushed load never waits, its MSHR may already be gone
    assign mshrWait = headEntry.memValid && !flushMemHead &&
                      headEntry.memIsLoad && headEntry.memHasMshr &&
                      mshrValid[headEntry.memMshrId] && !mshrReady[headEntry.memMshrId];

    assign pop = !empty && (releaseInterval >= headEntry.interval) && !mshrWait;

    assign stall = replayNow || almostFull;

    // Cycles since the last pop, saturating
    always_ff @(posedge clk) begin
        if (rst) begin
            releaseInterval <= '0;
        end else if (pop) begin
            releaseInterval <= '0;
        end else if (releaseInterval < ReplayPkg::RqInterval'(`RQ_MAX_INTERVAL)) begin
            releaseInterval <= releaseInterval + ReplayPkg::RqInterval'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            intReplayValid <= 1'b0;
            memReplayValid <= 1'b0;
            replayNow <= 1'b0;
        end else begin
            intReplayValid <= pop && headEntry.intValid && !flushIntHead;
            memReplayValid <= pop && headEntry.memValid && !flushMemHead;
            // Flushed ops still count as a replay cycle
            replayNow <= pop && headValid;
        end
    end

    // Op fields only matter when the matching valid is set
    always_ff @(posedge clk) begin
        intReplayTag <= headEntry.intTag;
        intReplayPayload <= headEntry.intPayload;
        memReplayTag <= headEntry.memTag;
        memReplayIsLoad <= headEntry.memIsLoad;
        memReplayPayload <= headEntry.memPayload;
    end

endmodule

//--- src/ReplayStorage.sv
// Circular entry store of the replay queue.
// Written at the tail on push, read combinationally at the head, freed on pop.

`timescale 1ns/100ps

`include "replayQueue_macros.svh"

module ReplayStorage (
    input logic clk,
    input logic rst,
    input logic push,
    input logic pop,
    input ReplayPkg::RqEntry recordEntry,
    output ReplayPkg::RqEntry headEntry,
    output logic empty,
    output logic full,
    output logic almostFull,
    output logic anyValidStored,
    output ReplayPkg::RqCount occupancy
);

    localparam ReplayPkg::RqCount AlmostFullLevel =
        ReplayPkg::RqCount'(`RQ_ENTRY_NUM - `RQ_MEM_LATENCY);

    ReplayPkg::RqEntry entries [`RQ_ENTRY_NUM];
    ReplayPkg::RqIndex headPtr;
    ReplayPkg::RqIndex tailPtr;
    ReplayPkg::RqCount validCount;
    logic pushValid;
    logic popValid;

    assign headEntry = entries[headPtr];

    // Entries that hold at least one op, as opposed to bubbles
    assign pushValid = push && (recordEntry.intValid || recordEntry.memValid);
    assign popValid = pop && (headEntry.intValid || headEntry.memValid);

    assign empty = (occupancy == '0);
    assign full = (occupancy == ReplayPkg::RqCount'(`RQ_ENTRY_NUM));
    assign almostFull = (occupancy >= AlmostFullLevel);
    assign anyValidStored = (validCount != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            entries[tailPtr] <= recordEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            occupancy <= '0;
            validCount <= '0;
        end else begin
            // Pointers wrap on their own since the depth is a power of two
            if (push) begin
                tailPtr <= tailPtr + ReplayPkg::RqIndex'(1);
            end
            if (pop) begin
                headPtr <= headPtr + ReplayPkg::RqIndex'(1);
            end

            case ({push, pop})
                2'b10: occupancy <= occupancy + ReplayPkg::RqCount'(1);
                2'b01: occupancy <= occupancy - ReplayPkg::RqCount'(1);
                default: occupancy <= occupancy;
            endcase

            case ({pushValid, popValid})
                2'b10: validCount <= validCount + ReplayPkg::RqCount'(1);
                2'b01: validCount <= validCount - ReplayPkg::RqCount'(1);
                default: validCount <= validCount;
            endcase
        end
    end

endmodule

//--- src/replayQueue_macros.svh
// Sizing constants for the scheduler replay queue.
// Include this header wherever a depth, width or limit of the queue is needed.

`ifndef REPLAY_QUEUE_MACROS_SVH
`define REPLAY_QUEUE_MACROS_SVH

// Queue depth and pointer width
`define RQ_ENTRY_NUM 16
`define RQ_INDEX_WIDTH 4

// Records that may still arrive after the stall is raised.
// The almost-full threshold leaves room for them.
`define RQ_MEM_LATENCY 3

// Saturation limit of the record and release interval counters
`define RQ_MAX_INTERVAL 7
`define RQ_INTERVAL_WIDTH 3

// Age tag width of the active list
`define RQ_ACTIVE_LIST_WIDTH 6

// MSHR entries seen by the queue
`define RQ_MSHR_NUM 4

// Opaque op data carried through the queue
`define RQ_PAYLOAD_WIDTH 16

`endif

//--- verification/ReplayQueueTb.sv
// Testbench for the replay queue.
// Runs random records, a load held by its MSHR and a wrapping flush range,
// and checks every replay against an in-order model of the recorded ops.

`timescale 1ns/100ps

`include "replayQueue_macros.svh"

module ReplayQueueTb;

    localparam int TimeoutCycles = 400;
    localparam int DrainCycles = `RQ_ENTRY_NUM + `RQ_MAX_INTERVAL;

    logic clk;
    logic rst;
    logic intRecordValid;
    ReplayPkg::ActiveListPtr intRecordTag;
    ReplayPkg::OpPayload intRecordPayload;
    logic memRecordValid;
    ReplayPkg::ActiveListPtr memRecordTag;
    logic memRecordIsLoad;
    logic memRecordHasMshr;
    ReplayPkg::MshrId memRecordMshrId;
    ReplayPkg::OpPayload memRecordPayload;
    logic [`RQ_MSHR_NUM-1:0] mshrValid;
    logic [`RQ_MSHR_NUM-1:0] mshrReady;
    logic toRecovery;
    ReplayPkg::ActiveListPtr flushHead;
    ReplayPkg::ActiveListPtr flushTail;
    logic flushAll;
    logic intReplayValid;
    ReplayPkg::ActiveListPtr intReplayTag;
    ReplayPkg::OpPayload intReplayPayload;
    logic memReplayValid;
    ReplayPkg::ActiveListPtr memReplayTag;
    logic memReplayIsLoad;
    ReplayPkg::OpPayload memReplayPayload;
    logic replay;
    logic stall;
    logic flushedOpExist;

    // Model of the queue holds the recorded entries in order with the cycle of each record
    ReplayPkg::RqEntry expected[$];
    int recordCycle[$];
    int cycle = 0;
    int lastReplayCycle = -1000;
    int lastRecordCycle = -1000;
    int errorCount = 0;
    logic stallSeen;
    logic flushSeen;
    logic [31:0] lcgState = 32'hf2cf_6648;

    TbClockGen clockGen_i (.clk(clk), .rst(rst));

    ReplayQueue dut_i (.*);

    bind ReplayQueue ReplayQueue_asserts asserts_i (
        .clk(clk),
        .rst(rst),
        .intRecordValid(intRecordValid),
        .memRecordValid(memRecordValid),
        .full(full),
        .replay(replay),
        .stall(stall),
        .flushedOpExist(flushedOpExist),
        .intReplayValid(intReplayValid),
        .memReplayValid(memReplayValid)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Distance from flushHead must be shorter than the span up to flushTail
    function automatic logic tagFlushed(input ReplayPkg::ActiveListPtr tag);
        ReplayPkg::ActiveListPtr offset;
        ReplayPkg::ActiveListPtr span;
        offset = tag - flushHead;
        span = flushTail - flushHead;
        return flushAll || (offset < span);
    endfunction

    task automatic reportFail(input string msg);
        errorCount++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic abortRun(input string reason);
        $display("Timeout: %s", reason);
        $display("Test failures found");
        $finish;
    endtask

    task automatic clearRecord();
        intRecordValid <= 1'b0;
        memRecordValid <= 1'b0;
        toRecovery <= 1'b0;
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            clearRecord();
        end
    endtask

    // One random record at the next edge where the queue is not stalling
    task automatic recordOp(input int tagBase, input int tagSpan, input logic blockedLoad);
        int waited;
        logic [31:0] r;
        logic [31:0] p;
        waited = 0;
        @(posedge clk);
        while (stallSeen) begin
            clearRecord();
            waited++;
            if (waited > TimeoutCycles) abortRun("stall stayed high and no op could be recorded");
            @(posedge clk);
        end
        r = nextRandom();
        p = nextRandom();
        intRecordValid <= r[0] || !r[1];
        memRecordValid <= r[1];
        intRecordTag <= ReplayPkg::ActiveListPtr'(tagBase + r[15:8] % tagSpan);
        memRecordTag <= ReplayPkg::ActiveListPtr'(tagBase + r[23:16] % tagSpan);
        memRecordIsLoad <= r[24];
        memRecordHasMshr <= r[25];
        memRecordMshrId <= r[27:26];
        intRecordPayload <= p[15:0];
        memRecordPayload <= p[31:16];
        if (blockedLoad) begin
            memRecordValid <= 1'b1;
            memRecordIsLoad <= 1'b1;
            memRecordHasMshr <= 1'b1;
            memRecordMshrId <= 2'd2;
        end
    endtask

    task automatic drainQueue();
        int waited;
        waited = 0;
        while (expected.size() != 0) begin
            @(posedge clk);
            clearRecord();
            waited++;
            if (waited > TimeoutCycles) abortRun("recorded ops were never replayed");
        end
        // Trailing bubbles leave one per cycle
        idleCycles(DrainCycles);
    endtask

    // Scoreboard samples at the falling edge where all signals are stable
    always @(negedge clk) begin
        ReplayPkg::RqEntry exp;
        int recCycle;
        int gap;
        cycle++;
        stallSeen = stall;
        flushSeen = flushedOpExist;
        if (rst === 1'b0 && replay) begin
            if (expected.size() == 0) begin
                reportFail("replay with no recorded op left");
            end else begin
                exp = expected.pop_front();
                recCycle = recordCycle.pop_front();
                gap = recCycle - lastRecordCycle;
                if (gap > `RQ_MAX_INTERVAL) gap = `RQ_MAX_INTERVAL;
                assert (intReplayValid == exp.intValid) else reportFail("int lane valid");
                assert (!exp.intValid || (intReplayTag == exp.intTag &&
                        intReplayPayload == exp.intPayload))
                    else reportFail("int lane tag or payload");
                assert (memReplayValid == exp.memValid) else reportFail("mem lane valid");
                assert (!exp.memValid || (memReplayTag == exp.memTag &&
                        memReplayIsLoad == exp.memIsLoad && memReplayPayload == exp.memPayload))
                    else reportFail("mem lane tag, load bit or payload");
                assert (cycle - recCycle >= 2) else reportFail("replay too soon after record");
                assert (cycle - lastReplayCycle >= gap)
                    else reportFail("replay spacing shorter than record spacing");
                lastReplayCycle = cycle;
                lastRecordCycle = recCycle;
            end
        end
        // Everything still queued at recovery is tested against the new range
        if (rst === 1'b0 && toRecovery) begin
            foreach (expected[i]) begin
                if (tagFlushed(expected[i].intTag)) expected[i].intValid = 1'b0;
                if (tagFlushed(expected[i].memTag)) expected[i].memValid = 1'b0;
            end
        end
        if (rst === 1'b0 && (intRecordValid || memRecordValid)) begin
            exp = '{intRecordValid, intRecordTag, intRecordPayload, memRecordValid,
                    memRecordTag, memRecordIsLoad, memRecordHasMshr, memRecordMshrId,
                    memRecordPayload, ReplayPkg::RqInterval'(0)};
            expected.push_back(exp);
            recordCycle.push_back(cycle);
        end
    end

    initial begin
        int waited;
        clearRecord();
        intRecordTag <= '0;
        intRecordPayload <= '0;
        memRecordTag <= '0;
        memRecordIsLoad <= 1'b0;
        memRecordHasMshr <= 1'b0;
        memRecordMshrId <= '0;
        memRecordPayload <= '0;
        mshrValid <= '1;
        mshrReady <= '1;
        flushHead <= '0;
        flushTail <= '0;
        flushAll <= 1'b0;
        waited = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > TimeoutCycles) abortRun("reset was never released");
        end

        // Random traffic with every MSHR ready
        repeat (40) begin
            recordOp(0, 64, 1'b0);
            idleCycles(1 + int'(nextRandom() % 9));
        end
        drainQueue();

        // Load waiting on MSHR 2 blocks the head while the queue fills
        mshrValid <= 4'b0100;
        mshrReady <= 4'b0000;
        recordOp(0, 64, 1'b1);
        repeat (`RQ_ENTRY_NUM - `RQ_MEM_LATENCY - 1) recordOp(0, 64, 1'b0);
        @(negedge clk);
        assert (!stall) else reportFail("stall high below the almost-full level");
        idleCycles(1);
        @(negedge clk);
        assert (stall) else reportFail("stall low at the almost-full level");
        repeat (2 * `RQ_MAX_INTERVAL) begin
            @(negedge clk);
            assert (!replay) else reportFail("replay while the head load waits on its MSHR");
        end
        @(posedge clk);
        mshrReady <= 4'b0100;
        drainQueue();

        // Wrapping flush range 48 up to 16 over a backlog held behind a waiting load
        mshrReady <= 4'b0000;
        recordOp(0, 64, 1'b1);
        repeat (8) recordOp(0, 64, 1'b0);
        @(posedge clk);
        clearRecord();
        toRecovery <= 1'b1;
        flushHead <= 6'd48;
        flushTail <= 6'd16;
        @(posedge clk);
        toRecovery <= 1'b0;
        mshrReady <= 4'b0100;
        @(negedge clk);
        assert (flushedOpExist) else reportFail("flushedOpExist did not rise after recovery");
        // Ops outside the range keep flowing until the pending count runs out
        waited = 0;
        do begin
            recordOp(16, 32, 1'b0);
            waited++;
            if (waited > TimeoutCycles) abortRun("flushedOpExist never fell");
        end while (flushSeen);
        idleCycles(1);
        drainQueue();

        $display("Checks failed: %0d, bound assertion failures: %0d",
                 errorCount, dut_i.asserts_i.failCount);
        if (errorCount == 0 && dut_i.asserts_i.failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verification/ReplayQueue_asserts.sv
// Concurrent checks on the replay queue, attached to ReplayQueue by bind.
// Covers stall during replay, replay valids, records while full and the reset state.

`timescale 1ns/100ps

module ReplayQueue_asserts (
    input logic clk,
    input logic rst,
    input logic intRecordValid,
    input logic memRecordValid,
    input logic full,
    input logic replay,
    input logic stall,
    input logic flushedOpExist,
    input logic intReplayValid,
    input logic memReplayValid
);

    int failCount = 0;

    // Upper stages are held during every replay cycle
    replayStalls: assert property (@(posedge clk) disable iff (rst) replay |-> stall)
        else begin
            failCount++;
            $error("replay is high while stall is low");
        end

    validNeedsReplay: assert property (@(posedge clk) disable iff (rst)
        (intReplayValid || memReplayValid) |-> replay)
        else begin
            failCount++;
            $error("a replay lane is valid while replay is low");
        end

    // A record into a full queue would be lost
    noRecordWhileFull: assert property (@(posedge clk) disable iff (rst)
        (intRecordValid || memRecordValid) |-> !full)
        else begin
            failCount++;
            $error("an op was recorded while the queue was full");
        end

    quietAfterReset: assert property (@(posedge clk) $fell(rst) |->
        !replay && !stall && !flushedOpExist && !intReplayValid && !memReplayValid)
        else begin
            failCount++;
            $error("status or replay outputs are not low right after reset");
        end

endmodule

//--- verification/TbClockGen.sv
// Clock and reset source for the replay queue testbench.
// 8 ns clock period, reset held high over the first 3 rising edges.

`timescale 1ns/100ps

module TbClockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verilog.f
+incdir+src
src/ReplayPkg.sv
src/ReplayRecorder.sv
src/ReplayStorage.sv
src/FlushRangeTracker.sv
src/ReplayReleaser.sv
src/ReplayQueue.sv
verification/TbClockGen.sv
verification/ReplayQueue_asserts.sv
verification/ReplayQueueTb.sv
